//--- logic/alut_addr_checker.sv
// packet engine; looks up the destination mac and learns the source mac into the table
`timescale 1ns/1ps

module alut_addr_checker
(
   input  logic                              pclk2,
   input  logic                              n_p_reset2,
   input  logic                              pkt_valid,     // one-cycle packet strobe
   input  logic [alut_entry_pkg::mac_w-1:0]  src_addr,
   input  logic [alut_entry_pkg::mac_w-1:0]  dst_addr,
   input  logic [alut_entry_pkg::port_w-1:0] src_port,
   alut_mem_if.client                        mem,
   alut_age_if.requester                     age,
   output logic                              result_valid,  // end of packet
   output logic                              dst_hit,
   output logic [alut_entry_pkg::port_w-1:0] dst_port
);
   import alut_entry_pkg::*;

   logic [1:0]        state;
   logic              start;      // packet accepted
   logic              dst_match;  // valid entry with the same mac
   logic [mac_w-1:0]  src_q;
   logic [mac_w-1:0]  dst_q;
   logic [port_w-1:0] port_q;

   // table index is the xor of the six mac bytes
   function automatic logic [alut_addr_w-1:0] hash(input logic [mac_w-1:0] mac);
      logic [alut_addr_w-1:0] h;
      h = '0;
      for (int i = 0; i < mac_w / 8; i++)
         h ^= mac[i*8 +: 8];
      return h;
   endfunction

   assign start     = (state == add_idle) && pkt_valid && !age.age_check_active;
   assign dst_match = mem.rdata[valid_bit] && (mem.rdata[mac_msb:mac_lsb] == dst_q);

   // ----------------------------------------
   // table port
   assign mem.addr  = (state == add_learn) ? hash(src_q) : hash(dst_q);
   assign mem.write = (state == add_learn);
   assign mem.wdata = {1'b1, age.curr_time, port_q, src_q};  // valid, time, port, mac

   assign age.add_check_active = (state != add_idle);

   // ----------------------------------------
   // FSM
   always_ff @(posedge pclk2 or negedge n_p_reset2)
   begin
      if (!n_p_reset2)
      begin
         state         <= add_idle;
         age.check_age <= 1'b0;
         result_valid  <= 1'b0;
         dst_hit       <= 1'b0;
      end
      else
      begin
         result_valid <= (state == add_learn);  // src entry lands on this edge
         case (state)
            add_idle:
               if (start)
                  state <= add_lookup;
            add_lookup:
               if (dst_match)
               begin
                  age.check_age <= 1'b1;          // hold until answered
                  state         <= add_age_wait;
               end
               else
               begin
                  dst_hit <= 1'b0;                // unknown destination
                  state   <= add_learn;
               end
            add_age_wait:
               if (age.age_confirmed)
               begin
                  age.check_age <= 1'b0;
                  dst_hit       <= age.age_ok;    // hit only while in date
                  state         <= add_learn;
               end
            default:
               state <= add_idle;
         endcase
      end
   end

   // packet and entry fields
   always_ff @(posedge pclk2)
   begin
      if (start)
      begin
         src_q  <= src_addr;
         dst_q  <= dst_addr;
         port_q <= src_port;
      end
      if (state == add_lookup)
      begin
         age.last_accessed <= mem.rdata[time_msb:time_lsb];
         dst_port          <= mem.rdata[port_msb:port_lsb];
      end
   end

   a_query_own: assert property (@(posedge pclk2) disable iff (!n_p_reset2)
      age.check_age |-> age.add_check_active);

   // age checker answers two cycles after the query goes out
   a_query_time: assert property (@(posedge pclk2) disable iff (!n_p_reset2)
      $rose(age.check_age) |-> ##2 age.age_confirmed);
endmodule

//--- logic/alut_age_checker.sv
// time base and age checker; answers packet age queries and sweeps the table on command
`timescale 1ns/1ps

module alut_age_checker
(
   input  logic                              pclk2,
   input  logic                              n_p_reset2,
   input  logic [alut_cmd_pkg::cmd_w-1:0]    command,       // sampled in idle
   input  logic [alut_cmd_pkg::div_w-1:0]    div_clk,       // time tick every div_clk+1
   input  logic [alut_entry_pkg::time_w-1:0] best_bfr_age,
   alut_mem_if.client                        mem,
   alut_age_if.responder                     age,
   output logic [alut_entry_pkg::mac_w-1:0]  lst_inv_addr,  // last aged entry cleared
   output logic [alut_entry_pkg::port_w-1:0] lst_inv_port,
   output logic                              inval_in_prog
);
   import alut_entry_pkg::*;
   import alut_cmd_pkg::*;

   logic [2:0]        state;
   logic [2:0]        nxt_state;
   logic [div_w-1:0]  clk_div_cnt;
   logic [time_w-1:0] stamp;       // time under test
   logic              sweep;       // age_chk runs for a sweep, not a query
   logic              aged;        // swept entry valid but out of date
   logic              last_addr;   // sweep at the top index
   logic              sweep_done;  // aged sweep leaves for idle

   // time since a stamp, across one counter wrap
   function automatic logic [time_w-1:0] elapsed(input logic [time_w-1:0] now_t,
                                                 input logic [time_w-1:0] then_t);
      return (now_t > then_t) ? now_t - then_t : now_t + (time_max - then_t);
   endfunction

   // ----------------------------------------
   // time base
   always_ff @(posedge pclk2 or negedge n_p_reset2)
   begin
      if (!n_p_reset2)
      begin
         clk_div_cnt   <= '0;
         age.curr_time <= '0;
      end
      else if (clk_div_cnt == div_clk)
      begin
         clk_div_cnt   <= '0;
         age.curr_time <= age.curr_time + 1'b1;  // one tick per divider period
      end
      else
         clk_div_cnt <= clk_div_cnt + 1'b1;
   end

   assign sweep     = ~age.add_check_active;  // no packet can run during a sweep
   assign stamp     = sweep ? mem.rdata[time_msb:time_lsb] : age.last_accessed;
   assign aged      = mem.rdata[valid_bit] & ~age.age_ok;
   assign last_addr = (mem.addr == alut_addr_w'(alut_depth - 1));

   // ----------------------------------------
   // FSM
   always_comb
   begin
      nxt_state = state;
      case (state)
         age_idle:
            if (age.check_age)
               nxt_state = age_chk;                      // queries win in idle
            else if (!age.add_check_active && command == cmd_inval_aged)
               nxt_state = age_aged_rd;
            else if (!age.add_check_active && command == cmd_inval_all)
               nxt_state = age_inval_all;
         age_aged_rd:
            nxt_state = age_chk;
         age_aged_wr:
            nxt_state = last_addr ? age_idle : age_aged_rd;
         age_inval_all:
            if (last_addr)
               nxt_state = age_idle;                     // index 0 written in idle
         age_chk:
            if (age.age_confirmed)
            begin
               if (!sweep)
                  nxt_state = age_idle;                  // query answered
               else if (aged)
                  nxt_state = age_aged_wr;
               else
                  nxt_state = last_addr ? age_idle : age_aged_rd;
            end
         default:
            nxt_state = age_idle;
      endcase
   end

   // state, sweep address and write strobe
   always_ff @(posedge pclk2 or negedge n_p_reset2)
   begin
      if (!n_p_reset2)
      begin
         state     <= age_idle;
         mem.addr  <= '0;
         mem.write <= 1'b0;
      end
      else
      begin
         state <= nxt_state;
         case (state)
            age_idle:
            begin
               mem.addr  <= '0;                          // every sweep starts at 0
               mem.write <= 1'b0;
            end
            age_inval_all:
            begin
               mem.addr  <= mem.addr + 1'b1;             // wraps for the closing write
               mem.write <= 1'b1;
            end
            age_aged_wr:
            begin
               mem.addr  <= mem.addr + 1'b1;
               mem.write <= 1'b0;
            end
            age_chk:
               if (age.age_confirmed && sweep)
               begin
                  mem.addr  <= aged ? mem.addr : mem.addr + 1'b1;
                  mem.write <= aged;                     // high through aged_wr
               end
            default:
               mem.write <= 1'b0;
         endcase
      end
   end

   assign mem.wdata            = '0;                     // clearing only
   assign age.age_check_active = (state != age_idle);

   // ----------------------------------------
   // age compare, one answer per visit
   always_ff @(posedge pclk2 or negedge n_p_reset2)
   begin
      if (!n_p_reset2)
      begin
         age.age_confirmed <= 1'b0;
         age.age_ok        <= 1'b0;
      end
      else if (state == age_chk && !age.age_confirmed)
      begin
         age.age_confirmed <= 1'b1;
         age.age_ok        <= best_bfr_age > elapsed(age.curr_time, stamp);
      end
      else
      begin
         age.age_confirmed <= 1'b0;
         age.age_ok        <= 1'b0;
      end
   end

   // in-progress flag spans the aged sweep from first clear to the top index
   assign sweep_done = (nxt_state == age_idle) &&
                       (state == age_aged_wr || (state == age_chk && sweep));

   always_ff @(posedge pclk2 or negedge n_p_reset2)
   begin
      if (!n_p_reset2)
         inval_in_prog <= 1'b0;
      else if (sweep_done)
         inval_in_prog <= 1'b0;
      else if (state == age_chk && sweep && age.age_confirmed && aged)
         inval_in_prog <= 1'b1;
   end

   // entry is still on the read port while it gets zeroed
   always_ff @(posedge pclk2)
   begin
      if (state == age_aged_wr)
      begin
         lst_inv_addr <= mem.rdata[mac_msb:mac_lsb];
         lst_inv_port <= mem.rdata[port_msb:port_lsb];
      end
   end

   a_confirm_pulse: assert property (@(posedge pclk2) disable iff (!n_p_reset2)
      age.age_confirmed |=> !age.age_confirmed);

   // the packet engine owns the table, so the sweep must hold its place
   a_sweep_hold: assert property (@(posedge pclk2) disable iff (!n_p_reset2)
      age.add_check_active |=> $stable(mem.addr));
endmodule

//--- logic/alut_age_if.sv
// age queries from the packet engine and the age checker's time and status back
`timescale 1ns/1ps

interface alut_age_if;
   import alut_entry_pkg::*;

   logic              check_age;         // held while a query waits
   logic [time_w-1:0] last_accessed;     // stored time of the queried entry
   logic              add_check_active;  // packet operation owns the table
   logic              age_confirmed;     // one-cycle answer strobe
   logic              age_ok;            // in date, only with age_confirmed
   logic [time_w-1:0] curr_time;         // running time base
   logic              age_check_active;  // age checker FSM busy

   modport requester
   (
      output check_age, last_accessed, add_check_active,
      input  age_confirmed, age_ok, curr_time, age_check_active
   );

   modport responder
   (
      input  check_age, last_accessed, add_check_active,
      output age_confirmed, age_ok, curr_time, age_check_active
   );
endinterface

//--- logic/alut_cmd_pkg.sv
// sweep command codes, time base constants and age checker states for design and testbench
package alut_cmd_pkg;

   // ----------------------------------------
   // sweep commands
   localparam int cmd_w = 2;
   localparam logic [cmd_w-1:0] cmd_none       = 2'b00;
   localparam logic [cmd_w-1:0] cmd_inval_aged = 2'b10;  // clear out-of-date entries
   localparam logic [cmd_w-1:0] cmd_inval_all  = 2'b11;  // clear every entry

   // time base
   localparam logic [31:0] time_max = 32'hffff_ffff;  // wrap point of the time counter
   localparam int          div_w    = 8;              // clock divider width

   // ----------------------------------------
   // age checker FSM
   localparam logic [2:0] age_idle      = 3'b000;
   localparam logic [2:0] age_aged_rd   = 3'b001;  // sweep entry on the read port
   localparam logic [2:0] age_aged_wr   = 3'b010;  // zero an aged entry
   localparam logic [2:0] age_inval_all = 3'b011;  // zero one entry per cycle
   localparam logic [2:0] age_chk       = 3'b100;  // age compare, query or sweep
endpackage

//--- logic/alut_entry_pkg.sv
// table geometry and entry word layout, imported by the table and both checkers
package alut_entry_pkg;

   // ----------------------------------------
   // table geometry
   localparam int alut_depth  = 256;     // number of entries
   localparam int alut_addr_w = 8;       // table index width
   localparam int entry_w     = 83;      // one stored word

   // ----------------------------------------
   // entry word fields
   localparam int mac_lsb   = 0;         // learned mac address
   localparam int mac_msb   = 47;
   localparam int port_lsb  = 48;        // port the mac came in on
   localparam int port_msb  = 49;
   localparam int time_lsb  = 50;        // time of last learn
   localparam int time_msb  = 81;
   localparam int valid_bit = 82;        // entry holds data

   localparam int mac_w  = 48;
   localparam int port_w = 2;
   localparam int time_w = 32;

   // packet engine sequencing over one entry read and one entry write
   localparam logic [1:0] add_idle     = 2'b00;
   localparam logic [1:0] add_lookup   = 2'b01;  // dst entry on the read port
   localparam logic [1:0] add_age_wait = 2'b10;  // query out to the age checker
   localparam logic [1:0] add_learn    = 2'b11;  // src entry written
endpackage

//--- logic/alut_mem.sv
// lookup table storage; the packet engine's port writes during a packet, the age port otherwise
`timescale 1ns/1ps

module alut_mem
(
   input  logic      pclk2,
   input  logic      n_p_reset2,
   alut_mem_if.store age_port,
   alut_mem_if.store addr_port,
   input  logic      add_check_active  // packet operation owns the table
);
   import alut_entry_pkg::*;

   logic [entry_w-1:0]     entries [alut_depth];
   logic                   wr_en;
   logic [alut_addr_w-1:0] wr_addr;
   logic [entry_w-1:0]     wr_data;

   // ----------------------------------------
   // writer select
   assign wr_en   = add_check_active ? addr_port.write : age_port.write;
   assign wr_addr = add_check_active ? addr_port.addr  : age_port.addr;
   assign wr_data = add_check_active ? addr_port.wdata : age_port.wdata;

   always_ff @(posedge pclk2 or negedge n_p_reset2)
   begin
      if (!n_p_reset2)
      begin
         for (int i = 0; i < alut_depth; i++)
            entries[i] <= '0;                    // empty table
      end
      else if (wr_en)
         entries[wr_addr] <= wr_data;
   end

   // both clients read at any time
   assign age_port.rdata  = entries[age_port.addr];
   assign addr_port.rdata = entries[addr_port.addr];

   a_age_no_write: assert property (@(posedge pclk2) disable iff (!n_p_reset2)
      add_check_active |-> !age_port.write);
endmodule

//--- logic/alut_mem_if.sv
// one read/write port of the lookup table; the client drives address and write data
`timescale 1ns/1ps

interface alut_mem_if;
   import alut_entry_pkg::*;

   logic [alut_addr_w-1:0] addr;   // entry index
   logic                   write;  // write on the rising edge
   logic [entry_w-1:0]     wdata;
   logic [entry_w-1:0]     rdata;  // combinational from addr

   modport client
   (
      output addr, write, wdata,
      input  rdata
   );

   modport store
   (
      input  addr, write, wdata,
      output rdata
   );
endinterface

//--- logic/alut_top.sv
// address lookup table top; table, packet engine and age checker behind plain ports
`timescale 1ns/1ps

module alut_top
(
   input  logic                              pclk2,
   input  logic                              n_p_reset2,
   input  logic                              pkt_valid,
   input  logic [alut_entry_pkg::mac_w-1:0]  src_addr,
   input  logic [alut_entry_pkg::mac_w-1:0]  dst_addr,
   input  logic [alut_entry_pkg::port_w-1:0] src_port,
   input  logic [alut_cmd_pkg::cmd_w-1:0]    command,
   input  logic [alut_cmd_pkg::div_w-1:0]    div_clk,
   input  logic [alut_entry_pkg::time_w-1:0] best_bfr_age,
   output logic                              result_valid,
   output logic                              dst_hit,
   output logic [alut_entry_pkg::port_w-1:0] dst_port,
   output logic [alut_entry_pkg::mac_w-1:0]  lst_inv_addr,
   output logic [alut_entry_pkg::port_w-1:0] lst_inv_port,
   output logic                              inval_in_prog,
   output logic                              age_check_active  // status, sweep or query busy
);

   alut_mem_if age_mem ();   // age checker side of the table
   alut_mem_if addr_mem ();  // packet engine side of the table
   alut_age_if age_bus ();

   alut_mem u_mem
   (
      .pclk2            (pclk2),
      .n_p_reset2       (n_p_reset2),
      .age_port         (age_mem),
      .addr_port        (addr_mem),
      .add_check_active (age_bus.add_check_active)
   );

   alut_age_checker u_age_checker
   (
      .pclk2         (pclk2),
      .n_p_reset2    (n_p_reset2),
      .command       (command),
      .div_clk       (div_clk),
      .best_bfr_age  (best_bfr_age),
      .mem           (age_mem),
      .age           (age_bus),
      .lst_inv_addr  (lst_inv_addr),
      .lst_inv_port  (lst_inv_port),
      .inval_in_prog (inval_in_prog)
   );

   alut_addr_checker u_addr_checker
   (
      .pclk2        (pclk2),
      .n_p_reset2   (n_p_reset2),
      .pkt_valid    (pkt_valid),
      .src_addr     (src_addr),
      .dst_addr     (dst_addr),
      .src_port     (src_port),
      .mem          (addr_mem),
      .age          (age_bus),
      .result_valid (result_valid),
      .dst_hit      (dst_hit),
      .dst_port     (dst_port)
   );

   assign age_check_active = age_bus.age_check_active;
endmodule

//--- test/alut_tb.sv
// testbench for the address lookup table; drives learn, lookup and sweep traffic against a model
`timescale 1ns/1ps

module alut_tb;
   import alut_entry_pkg::*;
   import alut_cmd_pkg::*;

   localparam logic [15:0] seed         = 16'd41;
   localparam int          pkt_timeout  = 12;    // cycles from strobe to result_valid
   localparam int          all_timeout  = 600;   // full clear is about 256 cycles
   localparam int          aged_timeout = 2000;  // aged sweep is about 3 cycles per entry

   logic              pclk2 = 1'b0;
   logic              n_p_reset2;
   logic              pkt_valid;
   logic [mac_w-1:0]  src_addr;
   logic [mac_w-1:0]  dst_addr;
   logic [port_w-1:0] src_port;
   logic [cmd_w-1:0]  command;
   logic [div_w-1:0]  div_clk;
   logic [time_w-1:0] best_bfr_age;
   logic              result_valid;
   logic              dst_hit;
   logic [port_w-1:0] dst_port;
   logic [mac_w-1:0]  lst_inv_addr;
   logic [port_w-1:0] lst_inv_port;
   logic              inval_in_prog;
   logic              age_check_active;

   // reference table and time base
   logic              model_valid [alut_depth];
   logic [mac_w-1:0]  model_mac   [alut_depth];
   logic [port_w-1:0] model_port  [alut_depth];
   logic [time_w-1:0] model_stamp [alut_depth];
   logic [time_w-1:0] model_time;
   logic [div_w-1:0]  model_div;

   logic [15:0]       lfsr;
   logic              exp_hit;       // expected at the next result_valid
   logic [port_w-1:0] exp_port;
   logic [mac_w-1:0]  exp_inv_addr;
   logic [port_w-1:0] exp_inv_port;
   bit                quiet;         // nothing has been issued yet
   bit                sweep_aged;    // aged sweep under way
   bit                inval_seen;    // inval_in_prog went high in this sweep

   alut_top i_dut
   (
      .pclk2            (pclk2),
      .n_p_reset2       (n_p_reset2),
      .pkt_valid        (pkt_valid),
      .src_addr         (src_addr),
      .dst_addr         (dst_addr),
      .src_port         (src_port),
      .command          (command),
      .div_clk          (div_clk),
      .best_bfr_age     (best_bfr_age),
      .result_valid     (result_valid),
      .dst_hit          (dst_hit),
      .dst_port         (dst_port),
      .lst_inv_addr     (lst_inv_addr),
      .lst_inv_port     (lst_inv_port),
      .inval_in_prog    (inval_in_prog),
      .age_check_active (age_check_active)
   );

   always #50 pclk2 = ~pclk2;  // 100 ns period

   // one time tick per div_clk+1 cycles, zero at reset
   always @(posedge pclk2 or negedge n_p_reset2)
   begin
      if (!n_p_reset2)
      begin
         model_div  <= '0;
         model_time <= '0;
      end
      else if (model_div == div_clk)
      begin
         model_div  <= '0;
         model_time <= model_time + 1;
      end
      else
         model_div <= model_div + 1;
   end

   always @(posedge pclk2)
      if (inval_in_prog)
         inval_seen <= 1'b1;

   // ----------------------------------------
   // reference rules
   function automatic logic [alut_addr_w-1:0] mac_index(input logic [mac_w-1:0] m);
      return m[7:0] ^ m[15:8] ^ m[23:16] ^ m[31:24] ^ m[39:32] ^ m[47:40];
   endfunction

   function automatic logic in_date(input logic [time_w-1:0] now_t,
                                    input logic [time_w-1:0] stamp);
      logic [time_w-1:0] gap;
      if (now_t > stamp)
         gap = now_t - stamp;
      else
         gap = now_t + (time_max - stamp);  // counter wrapped since the stamp
      return best_bfr_age > gap;
   endfunction

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};  // x^16+x^14+x^13+x^11+1
   endfunction

   task automatic take_bits(input int n, output logic [mac_w-1:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr = lfsr_step(lfsr);
         v    = {v[mac_w-2:0], lfsr[0]};  // one step per bit
      end
   endtask

   // ----------------------------------------
   // failure reporting
   task automatic abort_run();
      $display("Simulation FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic value_error(input string name, input logic [63:0] got,
                              input logic [63:0] want);
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, want);
      abort_run();
   endtask

   task automatic plain_error(input string msg);
      $display("Error: %s", msg);
      abort_run();
   endtask

   // ----------------------------------------
   // stimulus helpers
   task automatic send_packet(input logic [mac_w-1:0] s, input logic [mac_w-1:0] d,
                              input logic [port_w-1:0] p);
      logic [alut_addr_w-1:0] di;
      logic [alut_addr_w-1:0] si;
      logic [time_w-1:0]      learn_time;
      bit                     seen;
      di       = mac_index(d);
      exp_hit  = model_valid[di] && model_mac[di] == d && in_date(model_time, model_stamp[di]);
      exp_port = model_port[di];
      @(posedge pclk2);
      src_addr  <= s;
      dst_addr  <= d;
      src_port  <= p;
      pkt_valid <= 1'b1;
      @(posedge pclk2);
      pkt_valid <= 1'b0;
      seen = 0;
      for (int n = 0; n < pkt_timeout && !seen; n++)
      begin
         @(negedge pclk2);
         seen = result_valid;
         if (!seen)
            learn_time = model_time;         // src is written with the time of this cycle
      end
      if (!seen)
         plain_error("result_valid did not arrive after a packet strobe");
      @(posedge pclk2);                      // let the checks sample the result
      si              = mac_index(s);
      model_valid[si] = 1'b1;                // source is learned last
      model_mac[si]   = s;
      model_port[si]  = p;
      model_stamp[si] = learn_time;
   endtask

   task automatic run_sweep(input logic [cmd_w-1:0] cmd, input int limit);
      bit done;
      @(posedge pclk2);
      command <= cmd;
      @(posedge pclk2);
      command <= cmd_none;                   // one-cycle command
      done = 0;
      for (int n = 0; n < limit && !done; n++)
      begin
         @(negedge pclk2);
         done = !age_check_active;
      end
      if (!done)
         plain_error("age checker did not return to idle after a sweep command");
      @(posedge pclk2);
   endtask

   task automatic model_aged_clear();
      for (int i = 0; i < alut_depth; i++)
         if (model_valid[i] && !in_date(model_time, model_stamp[i]))
         begin
            exp_inv_addr   = model_mac[i];   // highest index wins
            exp_inv_port   = model_port[i];
            model_valid[i] = 1'b0;
         end
   endtask

   task automatic model_clear();
      for (int i = 0; i < alut_depth; i++)
         model_valid[i] = 1'b0;
   endtask

   // ----------------------------------------
   // checks
   a_quiet: assert property (@(posedge pclk2) disable iff (!n_p_reset2)
      quiet |-> !result_valid && !inval_in_prog && !age_check_active)
      else plain_error("status outputs were not idle after reset");

   a_pkt_free: assert property (@(posedge pclk2) disable iff (!n_p_reset2)
      pkt_valid |-> !age_check_active)
      else plain_error("packet strobe sent while the age checker was busy");

   a_cmd_free: assert property (@(posedge pclk2) disable iff (!n_p_reset2)
      command != cmd_none |-> !age_check_active)
      else plain_error("sweep command sent while the age checker was busy");

   a_hit: assert property (@(posedge pclk2) disable iff (!n_p_reset2)
      result_valid |-> dst_hit == exp_hit)
      else value_error("dst_hit", $sampled(dst_hit), exp_hit);

   a_port: assert property (@(posedge pclk2) disable iff (!n_p_reset2)
      result_valid && exp_hit |-> dst_port == exp_port)
      else value_error("dst_port", $sampled(dst_port), exp_port);

   a_inv_flag: assert property (@(posedge pclk2) disable iff (!n_p_reset2)
      $fell(age_check_active) && sweep_aged |-> inval_seen && !inval_in_prog)
      else plain_error("inval_in_prog did not rise and clear during the aged sweep");

   a_inv_addr: assert property (@(posedge pclk2) disable iff (!n_p_reset2)
      $fell(age_check_active) && sweep_aged |-> lst_inv_addr == exp_inv_addr)
      else value_error("lst_inv_addr", $sampled(lst_inv_addr), exp_inv_addr);

   a_inv_port: assert property (@(posedge pclk2) disable iff (!n_p_reset2)
      $fell(age_check_active) && sweep_aged |-> lst_inv_port == exp_inv_port)
      else value_error("lst_inv_port", $sampled(lst_inv_port), exp_inv_port);

   // ----------------------------------------
   initial
   begin : stimulus
      logic [mac_w-1:0]  a_mac;
      logic [mac_w-1:0]  b_mac;
      logic [mac_w-1:0]  r;
      logic [port_w-1:0] a_port;
      logic [port_w-1:0] b_port;
      logic [mac_w-1:0]  learned      [4];
      logic [port_w-1:0] learned_port [4];
      n_p_reset2   = 1'b0;
      pkt_valid    = 1'b0;
      src_addr     = '0;
      dst_addr     = '0;
      src_port     = '0;
      command      = cmd_none;
      div_clk      = '0;                     // one tick per cycle
      best_bfr_age = 32'h1000_0000;
      lfsr         = seed;
      quiet        = 1;
      model_clear();
      repeat (5) @(posedge pclk2);
      n_p_reset2 <= 1'b1;
      repeat (3) @(posedge pclk2);

      // unknown destination on an empty table
      quiet = 0;
      take_bits(48, r);
      take_bits(48, b_mac);
      send_packet(r, b_mac, 2'd0);

      // learn A, then hit it; same hash with another mac misses
      take_bits(48, a_mac);
      take_bits(2, r);
      a_port = r[1:0];
      take_bits(48, r);
      send_packet(a_mac, r, a_port);
      take_bits(48, r);
      send_packet(r, a_mac, 2'd1);
      take_bits(48, r);
      send_packet(r, a_mac ^ 48'h0000_0000_a5a5, 2'd2);

      // A ages out on lookup
      @(posedge pclk2);
      best_bfr_age <= 32'd20;
      repeat (50) @(posedge pclk2);
      take_bits(48, r);
      send_packet(r, a_mac, 2'd3);

      // aged sweep clears A and keeps fresh B
      run_sweep(cmd_inval_all, all_timeout);
      model_clear();
      @(posedge pclk2);
      best_bfr_age <= 32'd2000;
      take_bits(48, r);
      send_packet(a_mac, r, a_port);
      repeat (3000) @(posedge pclk2);
      take_bits(48, b_mac);
      if (mac_index(b_mac) == mac_index(a_mac))
         b_mac[0] = ~b_mac[0];               // keep B out of A's slot
      take_bits(2, r);
      b_port = r[1:0];
      take_bits(48, r);
      send_packet(b_mac, r, b_port);
      model_aged_clear();
      inval_seen = 0;
      sweep_aged = 1;
      run_sweep(cmd_inval_aged, aged_timeout);
      sweep_aged = 0;
      take_bits(48, r);
      send_packet(r, a_mac, 2'd0);
      take_bits(48, r);
      send_packet(r, b_mac, 2'd1);

      // full clear drops every learned entry
      @(posedge pclk2);
      best_bfr_age <= 32'h1000_0000;
      for (int i = 0; i < 4; i++)
      begin
         take_bits(48, learned[i]);
         take_bits(2, r);
         learned_port[i] = r[1:0];
         take_bits(48, r);
         send_packet(learned[i], r, learned_port[i]);
      end
      run_sweep(cmd_inval_all, all_timeout);
      model_clear();
      for (int i = 0; i < 4; i++)
      begin
         take_bits(48, r);
         send_packet(r, learned[i], 2'd2);
      end

      repeat (2) @(posedge pclk2);
      $display("Simulation PASSED");
      $finish;
   end
endmodule

//--- verilog.f
logic/alut_entry_pkg.sv
logic/alut_cmd_pkg.sv
logic/alut_mem_if.sv
logic/alut_age_if.sv
logic/alut_mem.sv
logic/alut_age_checker.sv
logic/alut_addr_checker.sv
logic/alut_top.sv
test/alut_tb.sv
